// ==== Bender.yml ====
package:
  name: useq_ctrl

sources:
  - files:
      - hw/useq_pkg.sv
      - hw/ucode_pkg.sv
      - hw/useq_core.sv
      - hw/ucode_store.sv
      - hw/map_vector_regs.sv
      - hw/useq_top.sv
  - target: test
    files:
      - testbench/useq_tb.sv

// ==== files.f ====
hw/useq_pkg.sv
hw/ucode_pkg.sv
hw/useq_core.sv
hw/ucode_store.sv
hw/map_vector_regs.sv
hw/useq_top.sv
testbench/useq_tb.sv

// ==== hw/map_vector_regs.sv ====
// map table and vector register beside the sequencer, drives the d bus from the active enable
`timescale 1ns/1ns

module map_vector_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [ucode_pkg::uword_w-1:0] pl_word,     // pipeline, data field source
    input  logic                          pl_n,        // pipeline on d
    input  logic                          map_n,       // map entry on d
    input  logic                          vect_n,      // vector register on d
    input  logic [3:0]                    map_opcode,  // map table index
    input  logic                          cfg_map_we,
    input  logic                          cfg_vect_we,
    input  logic [3:0]                    cfg_idx,
    input  logic [useq_pkg::addr_w-1:0]   cfg_data,
    output logic [useq_pkg::addr_w-1:0]   d
);

    logic [useq_pkg::addr_w-1:0]  map_tbl [16]; // opcode to start address
    logic [useq_pkg::addr_w-1:0]  vect_reg;
    logic [ucode_pkg::uf_data_w-1:0] pl_data;

    assign pl_data = pl_word[ucode_pkg::uf_data_lsb +: ucode_pkg::uf_data_w];

    // config writes, visible the cycle after the strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++)
                map_tbl[i] <= '0;
            vect_reg <= '0;
        end else begin
            if (cfg_map_we)
                map_tbl[cfg_idx] <= cfg_data;
            if (cfg_vect_we)
                vect_reg <= cfg_data; // both strobes may fire together
        end
    end

    // d source mux, the core keeps exactly one enable low
    always_comb begin
        d = '0;
        if (!pl_n)
            d = pl_data;
        else if (!map_n)
            d = map_tbl[map_opcode];
        else if (!vect_n)
            d = vect_reg;
    end

endmodule

// ==== hw/ucode_pkg.sv ====
// microword layout for the control store and everything that decodes it, use by scoped name
package ucode_pkg;

    localparam int uword_w = 32; // one control-store word

    // d value taken from the pipeline
    localparam int uf_data_lsb = 0;
    localparam int uf_data_w   = 12;

    // next-address instruction
    localparam int uf_instr_lsb = 12;
    localparam int uf_instr_w   = 4;

    // condition select, one of eight flags
    localparam int uf_cc_sel_lsb = 16;
    localparam int uf_cc_sel_w   = 3;

    localparam int uf_cc_inv_bit = 19; // test the flag inverted
    localparam int uf_ccen_bit   = 20; // clear means the condition always passes
    localparam int uf_rld_bit    = 21; // force a counter load from d

    // raw control bits handed to the outside
    localparam int uf_ctrl_lsb = 22;
    localparam int uf_ctrl_w   = 10;

    // pipeline contents after reset, jz with every other field zero
    localparam logic [uword_w-1:0] uword_reset =
        uword_w'(useq_pkg::i_jz) << uf_instr_lsb;

endpackage

// ==== hw/ucode_store.sv ====
// writable control store with the pipeline register, read at y each cycle by the controller top
`timescale 1ns/1ns

module ucode_store #(
    parameter int store_depth = 4096
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [useq_pkg::addr_w-1:0]   y,         // next address from the sequencer
    input  logic                          prog_we,   // single-cycle write strobe
    input  logic [useq_pkg::addr_w-1:0]   prog_addr,
    input  logic [ucode_pkg::uword_w-1:0] prog_data,
    output logic [ucode_pkg::uword_w-1:0] pl_word    // microword now executing
);

    logic [ucode_pkg::uword_w-1:0] mem [store_depth]; // no reset, survives rst_n

    // program port
    always_ff @(posedge clk) begin
        if (prog_we)
            mem[prog_addr] <= prog_data; // readable from the next cycle
    end

    // pipeline register, word at y executes next cycle
    always_ff @(posedge clk) begin
        if (!rst_n)
            pl_word <= ucode_pkg::uword_reset; // first cycle runs jz
        else
            pl_word <= mem[y];
    end

    // y feeds the read directly, must stay inside the store
    a_y_range: assert property (@(posedge clk) disable iff (!rst_n)
        y < store_depth);

endmodule

// ==== hw/useq_core.sv ====
// next-address sequencer core with stack, loop counter and upc, instantiated by the controller top
`timescale 1ns/1ns

module useq_core #(
    parameter int stack_depth = 5
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [ucode_pkg::uword_w-1:0] pl_word,    // executing microword
    input  logic [useq_pkg::addr_w-1:0]   d,          // d bus from the source the enables pick
    input  logic [7:0]                    cond_flags,
    input  logic                          run,        // carry-in of the upc incrementer
    output logic [useq_pkg::addr_w-1:0]   y,
    output logic                          pl_n,
    output logic                          map_n,
    output logic                          vect_n,
    output logic                          full_n
);
    localparam int sp_w = $clog2(stack_depth + 1); // pointer counts 0 .. stack_depth

    logic [3:0]                          instr;
    logic [ucode_pkg::uf_cc_sel_w-1:0]   cc_sel;
    logic                                cc_inv;
    logic                                ccen;
    logic                                rld;
    logic                                pass;   // condition met or test disabled
    logic                                r_zero; // loop counter at zero

    logic [useq_pkg::addr_w-1:0]         cnt;    // loop counter
    logic [useq_pkg::addr_w-1:0]         upc;    // microprogram counter
    logic [useq_pkg::addr_w-1:0]         stk [stack_depth];
    logic [sp_w-1:0]                     sp;     // number of valid entries
    logic [sp_w-1:0]                     wr_idx;
    logic [useq_pkg::addr_w-1:0]         top;

    // decoded controls
    logic sel_r;
    logic sel_d;
    logic sel_upc;
    logic sel_stk;
    logic push;
    logic pop;
    logic load;
    logic decr;
    logic clear;

    assign instr  = pl_word[ucode_pkg::uf_instr_lsb +: ucode_pkg::uf_instr_w];
    assign cc_sel = pl_word[ucode_pkg::uf_cc_sel_lsb +: ucode_pkg::uf_cc_sel_w];
    assign cc_inv = pl_word[ucode_pkg::uf_cc_inv_bit];
    assign ccen   = pl_word[ucode_pkg::uf_ccen_bit];
    assign rld    = pl_word[ucode_pkg::uf_rld_bit];

    // condition mux
    assign pass   = !ccen || (cond_flags[cc_sel] ^ cc_inv);
    assign r_zero = (cnt == '0);

    assign full_n = (sp != sp_w'(stack_depth));
    assign top    = (sp == '0) ? '0 : stk[sp - 1'b1]; // empty stack reads as zero
    assign wr_idx = full_n ? sp : sp - 1'b1;          // full push overwrites top

    // d source enables with exactly one low
    assign map_n  = (instr != useq_pkg::i_jmap);
    assign vect_n = (instr != useq_pkg::i_cjv);
    assign pl_n   = !(map_n && vect_n);

    always_comb begin
        sel_r   = 1'b0;
        sel_d   = 1'b0;
        sel_upc = 1'b0;
        sel_stk = 1'b0;
        push    = 1'b0;
        pop     = 1'b0;
        load    = 1'b0;
        decr    = 1'b0;
        clear   = 1'b0;
        case (instr)
            useq_pkg::i_jz: clear = 1'b1; // y stays at zero
            useq_pkg::i_cjs: begin
                sel_d   = pass;
                sel_upc = !pass;
                push    = pass;
            end
            useq_pkg::i_jmap: sel_d = 1'b1;
            useq_pkg::i_cjp, useq_pkg::i_cjv: begin
                sel_d   = pass;
                sel_upc = !pass;
            end
            useq_pkg::i_push: begin
                sel_upc = 1'b1;
                push    = 1'b1;
                load    = pass;
            end
            useq_pkg::i_jsrp: begin
                sel_d = pass;
                sel_r = !pass;
                push  = 1'b1;        // call either way
            end
            useq_pkg::i_jrp: begin
                sel_d = pass;
                sel_r = !pass;
            end
            useq_pkg::i_rfct: begin
                sel_stk = !r_zero;   // loop back to pushed address
                sel_upc = r_zero;
                decr    = !r_zero;
                pop     = r_zero;    // loop done so the entry is dropped
            end
            useq_pkg::i_rpct: begin
                sel_d   = !r_zero;
                sel_upc = r_zero;
                decr    = !r_zero;
            end
            useq_pkg::i_crtn: begin
                sel_stk = pass;
                sel_upc = !pass;
                pop     = pass;
            end
            useq_pkg::i_cjpp: begin
                sel_d   = pass;
                sel_upc = !pass;
                pop     = pass;
            end
            useq_pkg::i_ldct: begin
                sel_upc = 1'b1;
                load    = 1'b1;
            end
            useq_pkg::i_loop: begin
                sel_stk = !pass;
                sel_upc = pass;
                pop     = pass;
            end
            useq_pkg::i_cont: sel_upc = 1'b1;
            useq_pkg::i_twb: begin
                sel_upc = pass;
                sel_stk = !pass && !r_zero;
                sel_d   = !pass && r_zero;
                pop     = pass || r_zero;
                decr    = !r_zero;   // counts down on both pass and fail
            end
            default: ;
        endcase
    end

    // y mux where no source selected gives zero
    always_comb begin
        y = '0;
        if (sel_r)
            y = cnt;
        else if (sel_d)
            y = d;
        else if (sel_upc)
            y = upc;
        else if (sel_stk)
            y = top;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
            upc <= '0;
            sp  <= '0;
        end else begin
            upc <= y + {{(useq_pkg::addr_w - 1){1'b0}}, run}; // run low holds y
            if (load || rld)
                cnt <= d;
            else if (decr)
                cnt <= cnt - 1'b1;
            if (clear)
                sp <= '0;
            else if (pop && sp != '0)
                sp <= sp - 1'b1;
            else if (push && full_n)
                sp <= sp + 1'b1;     // full push keeps the pointer
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            stk[wr_idx] <= upc;      // return address is the executing word's address plus carry
    end

    a_sp_bound: assert property (@(posedge clk) disable iff (!rst_n)
        sp <= sp_w'(stack_depth));

    a_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push && !full_n |=> $stable(sp));

    a_src_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot({!pl_n, !map_n, !vect_n}));

endmodule

// ==== hw/useq_pkg.sv ====
// sequencer constants shared by the core, the store reset word and the testbench, use by scoped name
package useq_pkg;

    // width of y, d, the loop counter and every stack entry
    localparam int addr_w = 12;

    // return stack entries unless the top level asks for another depth
    localparam int stack_depth_dflt = 5;

    // next-address instruction codes, the classic sixteen in table order
    localparam logic [3:0] i_jz   = 4'd0;  // jump zero, clears the stack
    localparam logic [3:0] i_cjs  = 4'd1;  // conditional jump to subroutine
    localparam logic [3:0] i_jmap = 4'd2;  // jump via map table
    localparam logic [3:0] i_cjp  = 4'd3;  // conditional jump from pipeline
    localparam logic [3:0] i_push = 4'd4;  // push, load counter on pass
    localparam logic [3:0] i_jsrp = 4'd5;  // call to counter or pipeline
    localparam logic [3:0] i_cjv  = 4'd6;  // conditional jump via vector
    localparam logic [3:0] i_jrp  = 4'd7;  // jump to counter or pipeline
    localparam logic [3:0] i_rfct = 4'd8;  // repeat loop from stack top
    localparam logic [3:0] i_rpct = 4'd9;  // repeat from pipeline address
    localparam logic [3:0] i_crtn = 4'd10; // conditional return
    localparam logic [3:0] i_cjpp = 4'd11; // conditional jump and pop
    localparam logic [3:0] i_ldct = 4'd12; // load counter, continue
    localparam logic [3:0] i_loop = 4'd13; // test end of loop
    localparam logic [3:0] i_cont = 4'd14; // continue
    localparam logic [3:0] i_twb  = 4'd15; // three-way branch

endpackage

// ==== hw/useq_top.sv ====
// microprogrammed controller top, ties store, sequencer and map/vector block together for the testbench
`timescale 1ns/1ns

module useq_top #(
    parameter int stack_depth = useq_pkg::stack_depth_dflt,
    parameter int store_depth = 4096
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [7:0]                    cond_flags, // tested via cc_sel
    input  logic                          run,        // low holds the current address
    input  logic [3:0]                    map_opcode,
    input  logic                          prog_we,
    input  logic [useq_pkg::addr_w-1:0]   prog_addr,
    input  logic [ucode_pkg::uword_w-1:0] prog_data,
    input  logic                          cfg_map_we,
    input  logic                          cfg_vect_we,
    input  logic [3:0]                    cfg_idx,
    input  logic [useq_pkg::addr_w-1:0]   cfg_data,
    output logic [useq_pkg::addr_w-1:0]   y,
    output logic                          full_n,
    output logic [ucode_pkg::uf_ctrl_w-1:0] ctrl
);

    logic [ucode_pkg::uword_w-1:0] pl_word;
    logic [useq_pkg::addr_w-1:0]   d;
    logic                          pl_n;
    logic                          map_n;
    logic                          vect_n;

    // raw control field straight out of the pipeline
    assign ctrl = pl_word[ucode_pkg::uf_ctrl_lsb +: ucode_pkg::uf_ctrl_w];

    ucode_store #(
        .store_depth (store_depth)
    ) u_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .y         (y),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pl_word   (pl_word)
    );

    useq_core #(
        .stack_depth (stack_depth)
    ) u_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .pl_word    (pl_word),
        .d          (d),
        .cond_flags (cond_flags),
        .run        (run),
        .y          (y),
        .pl_n       (pl_n),
        .map_n      (map_n),
        .vect_n     (vect_n),
        .full_n     (full_n)
    );

    map_vector_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .pl_word     (pl_word),
        .pl_n        (pl_n),
        .map_n       (map_n),
        .vect_n      (vect_n),
        .map_opcode  (map_opcode),
        .cfg_map_we  (cfg_map_we),
        .cfg_vect_we (cfg_vect_we),
        .cfg_idx     (cfg_idx),
        .cfg_data    (cfg_data),
        .d           (d)
    );

endmodule

// ==== testbench/useq_tb.sv ====
// directed testbench for the microprogrammed controller, compile with files.f and run top useq_tb
`timescale 1ns/1ns

module useq_tb;
    localparam int aw        = useq_pkg::addr_w;
    localparam int uw        = ucode_pkg::uword_w;
    localparam int depth     = useq_pkg::stack_depth_dflt;
    localparam int n_words   = 64;                         // store span each test programs
    localparam int max_cyc   = 64;                         // longest checked window
    localparam int n_tests   = 6;
    localparam int test_cyc  = n_words + 2 + max_cyc + 2;  // program, reset, check, wrap-up
    localparam int limit_cyc = 8 + n_tests * test_cyc + 50;

    logic                            clk = 1'b0;
    logic                            rst_n;
    logic [7:0]                      cond_flags;
    logic                            run;
    logic [3:0]                      map_opcode;
    logic                            prog_we;
    logic [aw-1:0]                   prog_addr;
    logic [uw-1:0]                   prog_data;
    logic                            cfg_map_we;
    logic                            cfg_vect_we;
    logic [3:0]                      cfg_idx;
    logic [aw-1:0]                   cfg_data;
    logic [aw-1:0]                   y;
    logic                            full_n;
    logic [ucode_pkg::uf_ctrl_w-1:0] ctrl;

    // one test's program, then per-cycle stimulus and expected values
    logic [uw-1:0] prog_mem  [n_words];
    logic [aw-1:0] exp_y     [max_cyc];
    logic          exp_full  [max_cyc];
    logic [7:0]    cyc_flags [max_cyc];
    logic          cyc_run   [max_cyc];
    logic [aw+5:0] cyc_cfg   [max_cyc]; // {vect_we, map_we, idx, data}
    int            n_exp;
    integer        seed;
    int            checks    = 0;
    int            test_errs = 0;
    int            errors    = 0;
    int            tests_run = 0;
    int            tests_bad = 0;

    useq_top #(.stack_depth(depth), .store_depth(4096)) i_dut (.*);

    always #10 clk = ~clk;

    function automatic logic [uw-1:0] make_uword(input logic [3:0] instr,
                                                 input logic [aw-1:0] data,
                                                 input logic [2:0] cc_sel,
                                                 input logic cc_inv,
                                                 input logic ccen,
                                                 input logic [9:0] cbits);
        logic [uw-1:0] w;
        w = '0;
        w[ucode_pkg::uf_data_lsb +: ucode_pkg::uf_data_w]     = data;
        w[ucode_pkg::uf_instr_lsb +: ucode_pkg::uf_instr_w]   = instr;
        w[ucode_pkg::uf_cc_sel_lsb +: ucode_pkg::uf_cc_sel_w] = cc_sel;
        w[ucode_pkg::uf_cc_inv_bit] = cc_inv;
        w[ucode_pkg::uf_ccen_bit]   = ccen;  // clear means always pass
        w[ucode_pkg::uf_ctrl_lsb +: ucode_pkg::uf_ctrl_w]     = cbits;
        return w;
    endfunction

    // condition test off and no control bits
    function automatic logic [uw-1:0] plain_word(input logic [3:0] instr, input logic [aw-1:0] data);
        return make_uword(instr, data, 3'd0, 1'b0, 1'b0, 10'd0);
    endfunction

    task automatic clear_test();
        for (int i = 0; i < max_cyc; i++) begin
            exp_full[i]  = 1'b1;
            cyc_flags[i] = 8'h00;
            cyc_run[i]   = 1'b1;
            cyc_cfg[i]   = '0;
        end
        for (int i = 0; i < n_words; i++)
            prog_mem[i] = plain_word(useq_pkg::i_jz, 12'd0); // unused words park at zero
        n_exp = 0;
    endtask

    task automatic expect_y(input int addr);
        exp_y[n_exp] = aw'(addr);
        n_exp++;
    endtask

    // whole span written with the sequencer held in reset
    task automatic load_program();
        @(negedge clk);
        rst_n = 1'b0;
        run   = 1'b0;
        for (int a = 0; a < n_words; a++) begin
            prog_we   = 1'b1;
            prog_addr = aw'(a);
            prog_data = prog_mem[a];
            @(negedge clk);
        end
        prog_we = 1'b0;
    endtask

    task automatic check_value(input string sig, input logic [aw-1:0] got,
                               input logic [aw-1:0] want);
        checks++;
        assert (got === want) else begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, sig, got, want);
            test_errs++;
        end
    endtask

    // release reset, apply each cycle's inputs, check y, full_n and ctrl
    task automatic run_check(input string name);
        logic [uw-1:0]                   prev_word;
        logic [ucode_pkg::uf_ctrl_w-1:0] want_ctrl;
        test_errs = 0;
        for (int k = 0; k < n_exp; k++) begin
            @(negedge clk);
            rst_n      = 1'b1;
            run        = cyc_run[k];
            cond_flags = cyc_flags[k];
            {cfg_vect_we, cfg_map_we, cfg_idx, cfg_data} = cyc_cfg[k];
            #2;
            want_ctrl = '0;                  // reset word in the first cycle
            if (k > 0) begin
                prev_word = prog_mem[exp_y[k-1]]; // fetched at last cycle's address
                want_ctrl = prev_word[ucode_pkg::uf_ctrl_lsb +: ucode_pkg::uf_ctrl_w];
            end
            check_value("y", y, exp_y[k]);
            check_value("full_n", full_n, exp_full[k]);
            check_value("ctrl", ctrl, want_ctrl);
        end
        @(negedge clk);
        rst_n = 1'b0;
        run   = 1'b0;
        tests_run++;
        errors += test_errs;
        if (test_errs == 0) begin
            $display("%s: ok, %0d cycles", name, n_exp);
        end else begin
            $display("%s: %0d mismatches", name, test_errs);
            tests_bad++;
        end
    endtask

    task automatic test_cont_jump();
        clear_test();
        prog_mem[0] = make_uword(useq_pkg::i_cont, 12'd0, 3'd0, 1'b0, 1'b0, 10'h011);
        prog_mem[1] = make_uword(useq_pkg::i_cont, 12'd0, 3'd0, 1'b0, 1'b0, 10'h122);
        prog_mem[2] = make_uword(useq_pkg::i_cont, 12'd0, 3'd0, 1'b0, 1'b0, 10'h233);
        prog_mem[3] = make_uword(useq_pkg::i_cjp, 12'd8, 3'd0, 1'b0, 1'b0, 10'h344);
        prog_mem[8] = make_uword(useq_pkg::i_cont, 12'd0, 3'd0, 1'b0, 1'b0, 10'h055);
        prog_mem[9] = make_uword(useq_pkg::i_cjp, 12'd9, 3'd0, 1'b0, 1'b0, 10'h3ff);
        for (int a = 0; a < 4; a++)
            expect_y(a);
        expect_y(8);
        for (int i = 0; i < 3; i++)
            expect_y(9);                     // self jump holds here
        load_program();
        run_check("cont_jump");
    endtask

    // word j tests flag j%8, inverted for j >= 8; a taken jump lands on 32+j, which returns to j+1
    task automatic test_cond_branch();
        logic taken;
        clear_test();
        for (int j = 0; j < 16; j++) begin
            prog_mem[j]      = make_uword(useq_pkg::i_cjp, aw'(32 + j), 3'(j), j[3], 1'b1, 10'd0);
            prog_mem[32 + j] = plain_word(useq_pkg::i_cjp, aw'(j + 1));
        end
        prog_mem[16] = plain_word(useq_pkg::i_cjp, 12'd16);
        expect_y(0);
        for (int j = 0; j < 16; j++) begin
            cyc_flags[n_exp] = 8'($random(seed)); // cycle where word j executes
            taken = cyc_flags[n_exp][j % 8] ^ (j >= 8);
            if (taken) begin
                expect_y(32 + j);
                cyc_flags[n_exp] = 8'($random(seed));
                expect_y(j + 1);
            end else begin
                expect_y(j + 1);
            end
        end
        expect_y(16);
        expect_y(16);
        load_program();
        run_check("cond_branch");
    endtask

    // call at 10*i returns to 10*i+1; one call more than the stack holds
    task automatic test_stack();
        clear_test();
        for (int i = 0; i <= depth; i++)
            prog_mem[10 * i] = plain_word(useq_pkg::i_cjs, aw'(10 * (i + 1)));
        prog_mem[10 * (depth + 1)] = plain_word(useq_pkg::i_crtn, 12'd0);
        for (int i = 1; i <= depth; i++)
            prog_mem[10 * i + 1] = plain_word(useq_pkg::i_crtn, 12'd0);
        prog_mem[1] = plain_word(useq_pkg::i_cjp, 12'd1);
        for (int i = 0; i <= depth + 1; i++)
            expect_y(10 * i);
        exp_full[depth + 1] = 1'b0;          // pointer at depth after the last real push
        exp_full[depth + 2] = 1'b0;          // overwriting push left it there
        expect_y(10 * depth + 1);            // entry of the second-to-last call is lost
        for (int i = depth - 2; i >= 0; i--)
            expect_y(10 * i + 1);
        expect_y(1);
        expect_y(1);
        load_program();
        run_check("stack");
    endtask

    task automatic test_loops();
        clear_test();
        prog_mem[0] = plain_word(useq_pkg::i_ldct, 12'd3);
        prog_mem[1] = plain_word(useq_pkg::i_rpct, 12'd1);  // repeats itself
        prog_mem[2] = plain_word(useq_pkg::i_push, 12'd3);  // pushes 3 and loads the count
        prog_mem[3] = plain_word(useq_pkg::i_cont, 12'd0);
        prog_mem[4] = plain_word(useq_pkg::i_rfct, 12'd0);
        prog_mem[5] = plain_word(useq_pkg::i_cjp, 12'd5);
        expect_y(0);
        for (int i = 0; i <= 3; i++)
            expect_y(1);                     // count 3 gives four passes
        expect_y(2);
        for (int i = 0; i <= 3; i++) begin
            expect_y(3);
            expect_y(4);
        end
        for (int i = 0; i < 3; i++)
            expect_y(5);
        load_program();
        run_check("loops");
    endtask

    task automatic test_map_vect();
        clear_test();
        map_opcode = 4'd5;
        for (int a = 0; a < 3; a++)
            prog_mem[a] = plain_word(useq_pkg::i_cont, 12'd0);
        prog_mem[3]  = plain_word(useq_pkg::i_jmap, 12'd0);
        prog_mem[40] = make_uword(useq_pkg::i_cjv, 12'd0, 3'd2, 1'b0, 1'b1, 10'd0); // flag 2 set
        prog_mem[50] = make_uword(useq_pkg::i_cjv, 12'd0, 3'd3, 1'b0, 1'b1, 10'd0); // flag 3 clear
        prog_mem[51] = plain_word(useq_pkg::i_cjp, 12'd51);
        cyc_cfg[0] = {2'b01, 4'd5, 12'd40};
        cyc_cfg[1] = {2'b01, 4'd6, 12'd45};  // neighbour entry that jmap must not pick
        cyc_cfg[2] = {2'b10, 4'd0, 12'd50};  // vector register
        for (int k = 0; k < max_cyc; k++)
            cyc_flags[k] = 8'h04;
        for (int a = 0; a < 4; a++)
            expect_y(a);
        expect_y(40);
        expect_y(50);
        for (int i = 0; i < 3; i++)
            expect_y(51);                    // failed cjv falls through
        load_program();
        run_check("map_vect");
    endtask

    task automatic test_hold();
        clear_test();
        for (int a = 0; a < 6; a++)
            prog_mem[a] = plain_word(useq_pkg::i_cont, 12'd0);
        prog_mem[6] = plain_word(useq_pkg::i_cjp, 12'd6);
        for (int k = 2; k < 5; k++)
            cyc_run[k] = 1'b0;               // three cycles without carry-in
        expect_y(0);
        expect_y(1);
        for (int i = 0; i < 4; i++)
            expect_y(2);
        for (int a = 3; a <= 6; a++)
            expect_y(a);
        expect_y(6);
        expect_y(6);
        load_program();
        run_check("hold");
    endtask

    initial begin
        seed        = 35352;
        rst_n       = 1'b0;
        run         = 1'b0;
        cond_flags  = 8'h00;
        map_opcode  = 4'd0;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        cfg_map_we  = 1'b0;
        cfg_vect_we = 1'b0;
        cfg_idx     = 4'd0;
        cfg_data    = '0;
        repeat (8) @(posedge clk);
        test_cont_jump();
        test_cond_branch();
        test_stack();
        test_loops();
        test_map_vect();
        test_hold();
        $display("tests run %0d, tests with errors %0d, checks %0d, mismatches %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // bounded by the sum of all test windows
    initial begin
        #(limit_cyc * 20);
        $display("timeout, the run did not finish within %0d cycles", limit_cyc);
        $display("test failed");
        $finish;
    end

endmodule
